/* design/uop_pkg.sv */
`default_nettype none

package uop_pkg;

        //////////////////////////////
        // Micro-op and start fields.
        //////////////////////////////

        // One single-cycle micro-op.
        // A set dummy flag redirects that register field to DUMMY0.
        typedef struct packed {
                logic [31:0] instr;
                logic        rd_dummy;
                logic        rn_dummy;
                logic        rm_dummy;
        } uop_t;

        // Fields latched by a sequencer when it starts.
        typedef struct packed {
                logic [3:0] cond;
                logic       p;
                logic       u;
                logic       b;
                logic       w;
                logic       l;
                logic [3:0] rn;
                logic [3:0] rd;
                logic [3:0] rm;
        } xfer_t;

        // Bit i of an LDM/STM list selects register i.
        typedef logic [15:0] reglist_t;

        // Instruction classes seen by the decoder.
        typedef enum logic [1:0] {
                CLASS_PASS,
                CLASS_BLOCK,
                CLASS_SWAP
        } instr_class_t;

        //////////////////////////////
        // Encoding constants.
        //////////////////////////////

        // Always condition.
        localparam logic [3:0]  COND_AL      = 4'hE;

        // Data-processing opcodes.
        localparam logic [3:0]  OP_MOV       = 4'b1101;
        localparam logic [3:0]  OP_SUB       = 4'b0010;

        // Byte step between two word transfers.
        localparam logic [11:0] XFER_OFFSET  = 12'd4;

        // Field value placed where a dummy flag names DUMMY0.
        localparam logic [3:0]  DUMMY0_FIELD = 4'd0;

endpackage

`default_nettype wire

/* design/uop_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface uop_if;

        import uop_pkg::*;

        // Valid/ready micro-op channel.
        logic valid;
        logic ready;
        uop_t uop;
        // Final micro-op of an instruction.
        logic last;

        modport source (output valid, output uop, output last, input ready);
        modport sink   (input valid, input uop, input last, output ready);

endinterface

`default_nettype wire

/* design/instr_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module instr_decoder
(
        input  logic              i_instr_valid,
        input  logic [31:0]       i_instr,
        output logic              o_instr_ready,
        input  logic              i_block_busy,
        input  logic              i_swap_busy,
        output logic              o_block_start,
        output logic              o_swap_start,
        output uop_pkg::xfer_t    o_fields,
        output uop_pkg::reglist_t o_reglist,
        uop_if.source             pass_ch
);

        import uop_pkg::*;

        instr_class_t instr_class;
        logic         is_swap;
        logic         is_block;
        logic         seq_busy;

        //////////////////////////////
        // Classification.
        //////////////////////////////

        always_comb
        begin
                // SWP/SWPB pattern.
                is_swap  = (i_instr[27:23] == 5'b00010) && (i_instr[21:20] == 2'b00) &&
                           (i_instr[11:4] == 8'b0000_1001);
                // LDM/STM pattern.
                is_block = (i_instr[27:25] == 3'b100);

                if (is_swap)
                        instr_class = CLASS_SWAP;
                else if (is_block)
                        instr_class = CLASS_BLOCK;
                else
                        instr_class = CLASS_PASS;
        end

        // Same bit positions serve both LDM/STM and SWP.
        always_comb
        begin
                o_fields.cond = i_instr[31:28];
                o_fields.p    = i_instr[24];
                o_fields.u    = i_instr[23];
                o_fields.b    = i_instr[22];
                o_fields.w    = i_instr[21];
                o_fields.l    = i_instr[20];
                o_fields.rn   = i_instr[19:16];
                o_fields.rd   = i_instr[15:12];
                o_fields.rm   = i_instr[3:0];
        end

        assign o_reglist = i_instr[15:0];

        //////////////////////////////
        // Input handshake.
        //////////////////////////////

        // No new instruction while a sequence runs.
        assign seq_busy      = i_block_busy || i_swap_busy;
        // Issue slot must have room too.
        assign o_instr_ready = !seq_busy && pass_ch.ready;

        // Pass-through goes straight to the issue slot.
        assign pass_ch.valid = i_instr_valid && !seq_busy && (instr_class == CLASS_PASS);
        assign pass_ch.uop   = '{instr: i_instr, rd_dummy: 1'b0, rn_dummy: 1'b0, rm_dummy: 1'b0};
        assign pass_ch.last  = 1'b1;

        // One-cycle start pulses on acceptance.
        assign o_block_start = i_instr_valid && o_instr_ready && (instr_class == CLASS_BLOCK);
        assign o_swap_start  = i_instr_valid && o_instr_ready && (instr_class == CLASS_SWAP);

endmodule

`default_nettype wire

/* design/block_xfer_seq.sv */
`timescale 1ns/10ps
`default_nettype none

module block_xfer_seq
(
        input  logic              i_clk,
        input  logic              i_reset,
        input  logic              i_start,
        input  uop_pkg::xfer_t    i_fields,
        input  uop_pkg::reglist_t i_reglist,
        output logic              o_busy,
        uop_if.source             block_ch
);

        import uop_pkg::*;

        typedef enum logic [1:0] {
                ST_BACKUP,
                ST_XFER,
                ST_RESTORE
        } blk_state_t;

        blk_state_t  state_ff;
        blk_state_t  state_nxt;
        logic        busy_ff;
        xfer_t       fields_ff;
        reglist_t    list_ff;
        reglist_t    list_clr;
        logic [11:0] offset_ff;
        logic [4:0]  set_count;
        logic [3:0]  low_idx;
        logic        xfer_p;
        logic        fire;

        //////////////////////////////
        // List helpers.
        //////////////////////////////

        // Number of listed registers, for the 4n offset.
        always_comb
        begin
                set_count = 5'd0;
                for (int i = 0; i < 16; i++)
                        set_count = set_count + {4'd0, i_reglist[i]};
        end

        // Priority encoder where the lowest set bit wins.
        always_comb
        begin
                low_idx = 4'd0;
                for (int i = 15; i >= 0; i--)
                        if (list_ff[i])
                                low_idx = 4'(i);
                list_clr = list_ff & ~(16'd1 << low_idx);
        end

        // Decrementing modes swap pre and post indexing.
        assign xfer_p = fields_ff.u ? fields_ff.p : !fields_ff.p;
        assign fire   = block_ch.valid && block_ch.ready;

        //////////////////////////////
        // Micro-op build.
        //////////////////////////////

        always_comb
        begin
                block_ch.uop = '0;
                block_ch.last = 1'b0;
                state_nxt = state_ff;
                case (state_ff)
                ST_BACKUP:
                begin
                        // MOV DUMMY0, Rn  or  SUB DUMMY0, Rn, #4n.
                        if (fields_ff.u)
                                block_ch.uop.instr = {fields_ff.cond, 2'b00, 1'b0, OP_MOV, 1'b0,
                                                      4'd0, DUMMY0_FIELD, 8'd0, fields_ff.rn};
                        else
                                block_ch.uop.instr = {fields_ff.cond, 2'b00, 1'b1, OP_SUB, 1'b0,
                                                      fields_ff.rn, DUMMY0_FIELD, offset_ff};
                        block_ch.uop.rd_dummy = 1'b1;
                        // Empty list ends here unless a restore follows.
                        block_ch.last = (list_ff == '0) && !fields_ff.w;
                        state_nxt = (list_ff != '0) ? ST_XFER : ST_RESTORE;
                end
                ST_XFER:
                begin
                        // LDR/STR Rlow, [DUMMY0], #4 with writeback.
                        block_ch.uop.instr = {fields_ff.cond, 2'b01, 1'b0, xfer_p, 1'b1, 1'b0,
                                              xfer_p, fields_ff.l, DUMMY0_FIELD, low_idx,
                                              XFER_OFFSET};
                        block_ch.uop.rn_dummy = 1'b1;
                        block_ch.last = (list_clr == '0) && !fields_ff.w;
                        state_nxt = (list_clr != '0) ? ST_XFER : ST_RESTORE;
                end
                default:
                begin
                        // MOV Rn, DUMMY0  or  SUB Rn, Rn, #4n.
                        if (fields_ff.u)
                        begin
                                block_ch.uop.instr = {fields_ff.cond, 2'b00, 1'b0, OP_MOV, 1'b0,
                                                      4'd0, fields_ff.rn, 8'd0, DUMMY0_FIELD};
                                block_ch.uop.rm_dummy = 1'b1;
                        end
                        else
                        begin
                                block_ch.uop.instr = {fields_ff.cond, 2'b00, 1'b1, OP_SUB, 1'b0,
                                                      fields_ff.rn, fields_ff.rn, offset_ff};
                        end
                        block_ch.last = 1'b1;
                end
                endcase
        end

        assign block_ch.valid = busy_ff;
        assign o_busy         = busy_ff;

        //////////////////////////////
        // Sequence state.
        //////////////////////////////

        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        busy_ff  <= 1'b0;
                        state_ff <= ST_BACKUP;
                end
                else if (i_start)
                begin
                        busy_ff  <= 1'b1;
                        state_ff <= ST_BACKUP;
                end
                else if (fire)
                begin
                        // Drops after the final micro-op leaves.
                        busy_ff  <= !block_ch.last;
                        state_ff <= state_nxt;
                end
        end

        always_ff @(posedge i_clk)
        begin
                if (i_start)
                begin
                        fields_ff <= i_fields;
                        list_ff   <= i_reglist;
                        offset_ff <= {5'd0, set_count, 2'b00};
                end
                else if (fire && (state_ff == ST_XFER))
                begin
                        list_ff <= list_clr;
                end
        end

        // Registers are only ever removed from the list mid-sequence.
        a_list_shrinks: assert property (@(posedge i_clk) disable iff (i_reset)
                busy_ff |=> ((list_ff & ~$past(list_ff)) == '0));

endmodule

`default_nettype wire

/* design/swap_seq.sv */
`timescale 1ns/10ps
`default_nettype none

module swap_seq
(
        input  logic           i_clk,
        input  logic           i_reset,
        input  logic           i_start,
        input  uop_pkg::xfer_t i_fields,
        output logic           o_busy,
        uop_if.source          swap_ch
);

        import uop_pkg::*;

        logic       busy_ff;
        logic [1:0] step_ff;
        xfer_t      fields_ff;

        //////////////////////////////
        // Micro-op build.
        //////////////////////////////

        always_comb
        begin
                swap_ch.uop = '0;
                case (step_ff)
                2'd0:
                begin
                        // LDR DUMMY0, [Rn, #0].
                        swap_ch.uop.instr = {fields_ff.cond, 2'b01, 1'b0, 1'b1, 1'b1,
                                             fields_ff.b, 1'b0, 1'b1, fields_ff.rn,
                                             DUMMY0_FIELD, 12'd0};
                        swap_ch.uop.rd_dummy = 1'b1;
                end
                2'd1:
                begin
                        // STR Rm, [Rn, #0].
                        swap_ch.uop.instr = {fields_ff.cond, 2'b01, 1'b0, 1'b1, 1'b1,
                                             fields_ff.b, 1'b0, 1'b0, fields_ff.rn,
                                             fields_ff.rm, 12'd0};
                end
                default:
                begin
                        // MOV Rd, DUMMY0.
                        swap_ch.uop.instr = {fields_ff.cond, 2'b00, 1'b0, OP_MOV, 1'b0, 4'd0,
                                             fields_ff.rd, 8'd0, DUMMY0_FIELD};
                        swap_ch.uop.rm_dummy = 1'b1;
                end
                endcase
        end

        // Move closes the instruction.
        assign swap_ch.last  = (step_ff == 2'd2);
        assign swap_ch.valid = busy_ff;
        assign o_busy        = busy_ff;

        //////////////////////////////
        // Step counter.
        //////////////////////////////

        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        busy_ff <= 1'b0;
                        step_ff <= 2'd0;
                end
                else if (i_start)
                begin
                        busy_ff <= 1'b1;
                        step_ff <= 2'd0;
                end
                else if (swap_ch.valid && swap_ch.ready)
                begin
                        busy_ff <= !swap_ch.last;
                        step_ff <= step_ff + 2'd1;
                end
        end

        // Fields are held for the whole sequence.
        always_ff @(posedge i_clk)
        begin
                if (i_start)
                        fields_ff <= i_fields;
        end

endmodule

`default_nettype wire

/* design/uop_issue.sv */
`timescale 1ns/10ps
`default_nettype none

module uop_issue
(
        input  logic          i_clk,
        input  logic          i_reset,
        uop_if.sink           pass_ch,
        uop_if.sink           block_ch,
        uop_if.sink           swap_ch,
        output uop_pkg::uop_t o_uop,
        output logic          o_uop_last,
        output logic          o_uop_valid,
        input  logic          i_uop_ready
);

        import uop_pkg::*;

        logic slot_valid_ff;
        uop_t slot_uop_ff;
        logic slot_last_ff;
        logic take;
        logic src_valid;
        uop_t src_uop;
        logic src_last;

        // Slot is free or drains this cycle.
        assign take = !slot_valid_ff || i_uop_ready;

        // One ready for every source.
        assign pass_ch.ready  = take;
        assign block_ch.ready = take;
        assign swap_ch.ready  = take;

        //////////////////////////////
        // Source selector.
        //////////////////////////////

        assign src_valid = pass_ch.valid || block_ch.valid || swap_ch.valid;

        always_comb
        begin
                src_uop  = pass_ch.uop;
                src_last = pass_ch.last;
                if (block_ch.valid)
                begin
                        src_uop  = block_ch.uop;
                        src_last = block_ch.last;
                end
                else if (swap_ch.valid)
                begin
                        src_uop  = swap_ch.uop;
                        src_last = swap_ch.last;
                end
        end

        //////////////////////////////
        // Issue slot.
        //////////////////////////////

        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                        slot_valid_ff <= 1'b0;
                else if (take)
                        slot_valid_ff <= src_valid;
        end

        // Held under back-pressure.
        always_ff @(posedge i_clk)
        begin
                if (take && src_valid)
                begin
                        slot_uop_ff  <= src_uop;
                        slot_last_ff <= src_last;
                end
        end

        assign o_uop       = slot_uop_ff;
        assign o_uop_last  = slot_last_ff;
        assign o_uop_valid = slot_valid_ff;

        // Decoder and sequencers never offer at the same time.
        a_one_source: assert property (@(posedge i_clk) disable iff (i_reset)
                $onehot0({pass_ch.valid, block_ch.valid, swap_ch.valid}));

endmodule

`default_nettype wire

/* design/uop_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module uop_sequencer
(
        input  logic          i_clk,
        input  logic          i_reset,
        input  logic [31:0]   i_instr,
        input  logic          i_instr_valid,
        output logic          o_instr_ready,
        output uop_pkg::uop_t o_uop,
        output logic          o_uop_last,
        output logic          o_uop_valid,
        input  logic          i_uop_ready
);

        import uop_pkg::*;

        logic     block_busy;
        logic     swap_busy;
        logic     block_start;
        logic     swap_start;
        xfer_t    fields;
        reglist_t reglist;

        // Micro-op channels into the issue slot.
        uop_if pass_ch ();
        uop_if block_ch ();
        uop_if swap_ch ();

        instr_decoder u_decoder (
                .i_instr_valid (i_instr_valid),
                .i_instr       (i_instr),
                .o_instr_ready (o_instr_ready),
                .i_block_busy  (block_busy),
                .i_swap_busy   (swap_busy),
                .o_block_start (block_start),
                .o_swap_start  (swap_start),
                .o_fields      (fields),
                .o_reglist     (reglist),
                .pass_ch       (pass_ch.source)
        );

        block_xfer_seq u_block_seq (
                .i_clk     (i_clk),
                .i_reset   (i_reset),
                .i_start   (block_start),
                .i_fields  (fields),
                .i_reglist (reglist),
                .o_busy    (block_busy),
                .block_ch  (block_ch.source)
        );

        swap_seq u_swap_seq (
                .i_clk    (i_clk),
                .i_reset  (i_reset),
                .i_start  (swap_start),
                .i_fields (fields),
                .o_busy   (swap_busy),
                .swap_ch  (swap_ch.source)
        );

        uop_issue u_issue (
                .i_clk       (i_clk),
                .i_reset     (i_reset),
                .pass_ch     (pass_ch.sink),
                .block_ch    (block_ch.sink),
                .swap_ch     (swap_ch.sink),
                .o_uop       (o_uop),
                .o_uop_last  (o_uop_last),
                .o_uop_valid (o_uop_valid),
                .i_uop_ready (i_uop_ready)
        );

endmodule

`default_nettype wire

/* tests/uop_sequencer_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module uop_sequencer_tb;

        import uop_pkg::*;

        // About 40 instructions of up to 20 micro-ops each and doubled for back-pressure.
        localparam int          max_cycles  = 2000;
        // Longest drain is one sequence under random ready.
        localparam int          drain_limit = 200;
        localparam logic [3:0]  mov_opcode  = 4'b1101;
        localparam logic [3:0]  sub_opcode  = 4'b0010;
        // Register field value where a dummy flag names DUMMY0.
        localparam logic [3:0]  dummy_reg   = 4'd0;
        localparam logic [11:0] word_step   = 12'd4;

        // One expected output beat.
        typedef struct packed {
                logic last;
                uop_t uop;
        } exp_t;

        logic        i_clk         = 1'b0;
        logic        i_reset       = 1'b1;
        logic [31:0] i_instr       = '0;
        logic        i_instr_valid = 1'b0;
        logic        i_uop_ready   = 1'b1;
        logic        o_instr_ready;
        uop_t        o_uop;
        logic        o_uop_last;
        logic        o_uop_valid;

        exp_t        exp_q [$];
        logic        random_ready  = 1'b0;
        int          cycle_count   = 0;

        uop_sequencer uop_sequencer_i (
                .i_clk         (i_clk),
                .i_reset       (i_reset),
                .i_instr       (i_instr),
                .i_instr_valid (i_instr_valid),
                .o_instr_ready (o_instr_ready),
                .o_uop         (o_uop),
                .o_uop_last    (o_uop_last),
                .o_uop_valid   (o_uop_valid),
                .i_uop_ready   (i_uop_ready)
        );

        always #5 i_clk = ~i_clk;

        //////////////////////////////
        // Reporting.
        //////////////////////////////

        task automatic stop_run(input string why);
                $display("%s", why);
                $display("TEST FAILED");
                $fatal(1, "simulation stopped");
        endtask

        task automatic check_value(input string what, input logic [63:0] got,
                                   input logic [63:0] expected);
                if (got !== expected)
                        stop_run($sformatf("ERROR at %0t ns: %s is %h, expected %h",
                                           $time, what, got, expected));
        endtask

        //////////////////////////////
        // Reference expansion.
        //////////////////////////////

        // Data-processing word with the S bit clear.
        function automatic logic [31:0] dp_word(input logic [3:0] cond, input logic imm,
                                                input logic [3:0] opcode, input logic [3:0] rn,
                                                input logic [3:0] rd, input logic [11:0] op2);
                return {cond, 2'b00, imm, opcode, 1'b0, rn, rd, op2};
        endfunction

        // Single transfer with an immediate offset.
        function automatic logic [31:0] sdt_word(input logic [3:0] cond, input logic p,
                                                 input logic u, input logic b, input logic w,
                                                 input logic l, input logic [3:0] rn,
                                                 input logic [3:0] rd, input logic [11:0] offset);
                return {cond, 2'b01, 1'b0, p, u, b, w, l, rn, rd, offset};
        endfunction

        // Dummy flags are ordered rd, rn, rm.
        function automatic void add_exp(input logic [31:0] instr, input logic [2:0] dummies,
                                        input logic last);
                exp_t e;
                e.uop.instr    = instr;
                e.uop.rd_dummy = dummies[2];
                e.uop.rn_dummy = dummies[1];
                e.uop.rm_dummy = dummies[0];
                e.last         = last;
                exp_q.push_back(e);
        endfunction

        function automatic void expand_instr(input logic [31:0] instr);
                logic [3:0]  cond;
                logic [3:0]  rn;
                logic        up;
                logic        wb;
                logic        pt;
                logic [11:0] span;
                int          n;
                int          seen;
                cond = instr[31:28];
                rn   = instr[19:16];
                up   = instr[23];
                wb   = instr[21];
                if ((instr[27:23] == 5'b00010) && (instr[21:20] == 2'b00) &&
                    (instr[11:4] == 8'b0000_1001))
                begin
                        // SWP/SWPB as load, store, move.
                        add_exp(sdt_word(cond, 1'b1, 1'b1, instr[22], 1'b0, 1'b1, rn,
                                         dummy_reg, 12'd0), 3'b100, 1'b0);
                        add_exp(sdt_word(cond, 1'b1, 1'b1, instr[22], 1'b0, 1'b0, rn,
                                         instr[3:0], 12'd0), 3'b000, 1'b0);
                        add_exp(dp_word(cond, 1'b0, mov_opcode, 4'd0, instr[15:12],
                                        {8'd0, dummy_reg}), 3'b001, 1'b1);
                end
                else if (instr[27:25] == 3'b100)
                begin
                        n    = $countones(instr[15:0]);
                        span = 12'(4 * n);
                        // Decrementing modes flip pre and post indexing.
                        pt   = up ? instr[24] : !instr[24];
                        if (up)
                                add_exp(dp_word(cond, 1'b0, mov_opcode, 4'd0, dummy_reg,
                                                {8'd0, rn}), 3'b100, (n == 0) && !wb);
                        else
                                add_exp(dp_word(cond, 1'b1, sub_opcode, rn, dummy_reg, span),
                                        3'b100, (n == 0) && !wb);
                        seen = 0;
                        for (int r = 0; r < 16; r++)
                        begin
                                if (instr[r])
                                begin
                                        seen = seen + 1;
                                        add_exp(sdt_word(cond, pt, 1'b1, 1'b0, pt, instr[20],
                                                         dummy_reg, 4'(r), word_step),
                                                3'b010, (seen == n) && !wb);
                                end
                        end
                        if (wb && up)
                                add_exp(dp_word(cond, 1'b0, mov_opcode, 4'd0, rn,
                                                {8'd0, dummy_reg}), 3'b001, 1'b1);
                        else if (wb)
                                add_exp(dp_word(cond, 1'b1, sub_opcode, rn, rn, span),
                                        3'b000, 1'b1);
                end
                else
                begin
                        add_exp(instr, 3'b000, 1'b1);
                end
        endfunction

        //////////////////////////////
        // Monitors.
        //////////////////////////////

        // Expectations are queued on acceptance and popped on issue.
        always @(posedge i_clk)
        begin
                exp_t head;
                if (!i_reset)
                begin
                        // With both sequencers idle only the slot can hold a micro-op.
                        if (o_instr_ready && (exp_q.size() > 1))
                                stop_run("Input was ready while a sequence was still running");
                        else if (o_uop_valid && i_uop_ready && (exp_q.size() == 0))
                                stop_run("A micro-op was issued that no instruction called for");
                        else
                        begin
                                if (o_uop_valid && i_uop_ready)
                                begin
                                        head = exp_q.pop_front();
                                        check_value("micro-op", 64'(o_uop), 64'(head.uop));
                                        check_value("last flag", 64'(o_uop_last), 64'(head.last));
                                end
                                if (i_instr_valid && o_instr_ready)
                                        expand_instr(i_instr);
                        end
                end
        end

        always @(posedge i_clk)
        begin
                cycle_count = cycle_count + 1;
                if (cycle_count > max_cycles)
                        stop_run($sformatf("Timeout after %0d cycles with tests still running",
                                           max_cycles));
        end

        // Output back-pressure.
        always @(negedge i_clk)
        begin
                if (random_ready)
                        i_uop_ready = 1'($urandom % 2);
                else
                        i_uop_ready = 1'b1;
        end

        //////////////////////////////
        // Drivers.
        //////////////////////////////

        // Present one instruction and hold it until accepted.
        task automatic send_instr(input logic [31:0] instr);
                @(negedge i_clk);
                i_instr       = instr;
                i_instr_valid = 1'b1;
                @(posedge i_clk);
                while (!o_instr_ready)
                        @(posedge i_clk);
        endtask

        // Idle the input and wait for every expected micro-op to leave.
        task automatic wait_drain();
                int waited;
                waited = 0;
                @(negedge i_clk);
                i_instr_valid = 1'b0;
                while ((exp_q.size() != 0) && (waited < drain_limit))
                begin
                        @(negedge i_clk);
                        waited = waited + 1;
                end
                if (exp_q.size() != 0)
                        stop_run($sformatf("%0d expected micro-ops were never issued",
                                           exp_q.size()));
                check_value("valid after drain", 64'(o_uop_valid), 64'd0);
        endtask

        //////////////////////////////
        // Directed tests.
        //////////////////////////////

        task automatic pass_through_cases();
                // MOV, ADD, B, BL, MUL and LDR.
                send_instr(32'hE1A01002);
                send_instr(32'hE2843005);
                send_instr(32'hEA000010);
                send_instr(32'hEB000004);
                send_instr(32'hE0000291);
                send_instr(32'hE5912004);
                // Swap lookalike with bit 20 set.
                send_instr(32'hE1131092);
                wait_drain();
        endtask

        task automatic ldmia_writeback();
                // LDMIA r0!, {r1, r2, r5}.
                send_instr(32'hE8B00026);
                wait_drain();
                // STMIA r9!, {r8, r9}.
                send_instr(32'hE8A90300);
                wait_drain();
        endtask

        task automatic decrement_modes();
                // STMDB sp!, {r4, r5, lr}.
                send_instr(32'hE92D4030);
                wait_drain();
                // LDMDA r3, {r0, r7} with pre-indexed transfers.
                send_instr(32'hE8130081);
                wait_drain();
        endtask

        task automatic no_restore_and_empty();
                // LDMIBNE r2, {r0, r3, r8}.
                send_instr(32'h19920109);
                // Empty lists with and without writeback.
                send_instr(32'hE8B40000);
                send_instr(32'hE92D0000);
                send_instr(32'hE8940000);
                wait_drain();
        endtask

        task automatic swap_cases();
                // SWP, SWPB and SWPGT.
                send_instr(32'hE1031092);
                send_instr(32'hE1464095);
                send_instr(32'hC1031092);
                wait_drain();
        endtask

        task automatic mixed_stream();
                logic [31:0] stream [0:11];
                stream = '{32'hE1A01002, 32'hE8B00026, 32'hE1031092, 32'hEA000010,
                           32'hE92D4030, 32'hE2843005, 32'h19920109, 32'hE1464095,
                           32'hE8B40000, 32'hE0000291, 32'hE8130081, 32'hE5912004};
                random_ready = 1'b1;
                for (int pass = 0; pass < 2; pass++)
                        for (int k = 0; k < 12; k++)
                                send_instr(stream[k]);
                wait_drain();
                random_ready = 1'b0;
        endtask

        initial
        begin
                void'($urandom(64));
                repeat (16) @(posedge i_clk);
                @(negedge i_clk);
                i_reset = 1'b0;
                check_value("valid after reset", 64'(o_uop_valid), 64'd0);
                check_value("input ready after reset", 64'(o_instr_ready), 64'd1);

                pass_through_cases();
                ldmia_writeback();
                decrement_modes();
                no_restore_and_empty();
                swap_cases();
                mixed_stream();

                $display("TEST OK");
                $finish;
        end

endmodule

`default_nettype wire

/* verilog.f */
design/uop_pkg.sv
design/uop_if.sv
design/instr_decoder.sv
design/block_xfer_seq.sv
design/swap_seq.sv
design/uop_issue.sv
design/uop_sequencer.sv
tests/uop_sequencer_tb.sv

/* Makefile */
VERILATOR  = verilator
VFLAGS     = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing -Wall
TOP        = uop_sequencer_tb
FILELIST   = verilog.f
OBJ_DIR    = obj_dir
PASS_MSG   = TEST OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
